/* hdl/spi_char_pkg.sv */
`default_nettype none

package spi_char_pkg;

    localparam int CHAR_NBITS = 16; // widest character
    localparam int LEN_W      = 4;  // char_len code width
    localparam int DIV_W      = 8;  // sck divider width
    localparam int NUM_SLOTS  = 2;  // client slots behind the arbiter

    // encoded as {cpol, cpha}
    typedef enum logic [1:0] {
        MODE0 = 2'b00,
        MODE1 = 2'b01,
        MODE2 = 2'b10,
        MODE3 = 2'b11
    } spi_mode_e;

    typedef enum logic [1:0] {
        IDLE,  // cs_n high, waiting for start
        LEAD,  // cs_n low, before the first sck edge
        SHIFT, // sck edges running
        TRAIL  // release cs_n, then report
    } trx_state_e;

    typedef struct packed {
        logic             cpol;     // sck idle level
        logic             cpha;     // 1: shift on first edge
        logic             rev;      // 1: msb first
        logic             tx_only;  // leave rchar untouched
        logic             loop;     // receive own mosi
        logic [LEN_W-1:0] char_len; // 0: 16 bits, n: n+1 bits
        logic [DIV_W-1:0] divider;  // half period is divider+1 clocks
    } spi_cfg_t;

    typedef struct packed {
        spi_cfg_t              cfg;
        logic [CHAR_NBITS-1:0] wchar;
    } spi_req_t;

    typedef struct packed {
        logic [CHAR_NBITS-1:0] rchar;
        logic                  done; // one-cycle pulse
    } spi_rsp_t;

endpackage

`default_nettype wire

/* hdl/spi_sck_gen.sv */
`default_nettype none

// lead and trail are high in the cycle before the matching sck toggle,
// so logic using them changes state at the same clock edge as sck
module spi_sck_gen import spi_char_pkg::*; (
    input  logic             S_CHAR_GO,
    input  logic             S_RESETN,
    input  logic             run,     // character on the wire
    input  logic             cpol,    // sck level at rest
    input  logic [DIV_W-1:0] divider,
    output logic             sck,
    output logic             lead,    // first edge of the period is due
    output logic             trail    // second edge of the period is due
);

    logic [DIV_W-1:0] cnt;   // clocks left in this half period
    logic             phase; // 0: next toggle is a lead edge
    logic             tick;

    assign tick  = run && (cnt == '0);
    assign lead  = tick && !phase;
    assign trail = tick && phase;

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            cnt   <= '0;
            phase <= 1'b0;
            sck   <= 1'b0;
        end else if (!run) begin
            cnt   <= divider;     // reload for the next character
            phase <= 1'b0;
            sck   <= cpol;
        end else if (tick) begin
            cnt   <= divider;
            phase <= !phase;
            sck   <= !sck;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/spi_char_trx.sv */
`default_nettype none

module spi_char_trx import spi_char_pkg::*; (
    input  logic             S_CHAR_GO,
    input  logic             S_RESETN,
    input  logic             start,    // one-cycle strobe from the arbiter
    input  spi_req_t         req,
    output logic             idle,
    output spi_rsp_t         rsp,
    output logic             cs_n,
    output logic             mosi,
    input  logic             miso,
    output logic             gen_run,
    output logic             gen_cpol,
    output logic [DIV_W-1:0] gen_div,
    input  logic             lead,
    input  logic             trail
);

    trx_state_e            state;
    spi_cfg_t              cfg_q;     // settings of the character in flight
    logic [CHAR_NBITS-1:0] wchar_q;
    logic [CHAR_NBITS-1:0] rx_q;
    logic [LEN_W-1:0]      idx;       // bit currently on the wire
    logic [LEN_W-1:0]      first_idx;
    logic [LEN_W-1:0]      last_idx;
    logic [LEN_W-1:0]      next_idx;
    spi_mode_e             mode;
    logic                  sample_on_lead;
    logic                  din;

    // highest bit index for a length code
    function automatic logic [LEN_W-1:0] top_bit(input logic [LEN_W-1:0] len);
        return (len == '0) ? LEN_W'(CHAR_NBITS - 1) : len;
    endfunction

    assign idle    = (state == IDLE);
    assign gen_run = (state == LEAD) || (state == SHIFT);

    // new polarity and divider must reach the generator before cs_n falls
    assign gen_cpol = start ? req.cfg.cpol : cfg_q.cpol;
    assign gen_div  = start ? req.cfg.divider : cfg_q.divider;

    assign mode = spi_mode_e'({cfg_q.cpol, cfg_q.cpha});

    always_comb begin
        case (mode)
            MODE0, MODE2: sample_on_lead = 1'b1; // cpha 0
            default:      sample_on_lead = 1'b0; // cpha 1 samples on trail
        endcase
    end

    assign first_idx = req.cfg.rev ? top_bit(req.cfg.char_len) : '0;
    assign last_idx  = cfg_q.rev ? '0 : top_bit(cfg_q.char_len);
    assign next_idx  = cfg_q.rev ? idx - 1'b1 : idx + 1'b1;
    assign din       = cfg_q.loop ? mosi : miso;

    // shift data
    always_ff @(posedge S_CHAR_GO) begin
        if (idle && start) begin
            wchar_q <= req.wchar;
            rx_q    <= '0;        // bits above the length stay zero
        end else if ((lead && sample_on_lead) || (trail && !sample_on_lead)) begin
            rx_q[idx] <= din;
        end
    end

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state <= IDLE;
            cfg_q <= '0;          // sck rests low until the first character
            idx   <= '0;
            cs_n  <= 1'b1;
            mosi  <= 1'b1;
            rsp   <= '0;
        end else begin
            rsp.done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        cfg_q <= req.cfg;
                        idx   <= first_idx;
                        cs_n  <= 1'b0;
                        if (!req.cfg.cpha) begin
                            mosi <= req.wchar[first_idx]; // valid before first edge
                        end
                        state <= LEAD;
                    end
                end
                LEAD, SHIFT: begin
                    if (lead) begin
                        state <= SHIFT;
                        if (!sample_on_lead) begin
                            mosi <= wchar_q[idx];
                        end
                    end
                    if (trail) begin
                        if (idx == last_idx) begin
                            state <= TRAIL;   // that was the last edge
                        end else begin
                            idx <= next_idx;
                            if (sample_on_lead) begin
                                mosi <= wchar_q[next_idx];
                            end
                        end
                    end
                end
                TRAIL: begin
                    if (!cs_n) begin
                        cs_n <= 1'b1;
                        mosi <= 1'b1;
                        if (!cfg_q.tx_only) begin
                            rsp.rchar <= rx_q;
                        end
                    end else begin
                        rsp.done <= 1'b1; // one clock after cs_n rises
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/spi_bus_arbiter.sv */
`default_nettype none

module spi_bus_arbiter import spi_char_pkg::*; (
    input  logic                 S_CHAR_GO,
    input  logic                 S_RESETN,
    input  logic [NUM_SLOTS-1:0] pending,
    input  spi_req_t             held [NUM_SLOTS],
    input  logic                 idle,
    output logic [NUM_SLOTS-1:0] grant,
    output logic                 start,
    output spi_req_t             sel_req,
    input  spi_rsp_t             rsp,
    output spi_rsp_t             slot_rsp [NUM_SLOTS]
);

    logic prio;      // winner of the next tie
    logic owner;     // slot holding the transceiver
    logic pick;
    logic tie;
    logic can_grant;

    assign tie = pending[0] && pending[1];
    // start is still in flight while the transceiver reports idle
    assign can_grant = idle && !start && (pending != '0);
    assign pick      = tie ? prio : pending[1];

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            prio  <= 1'b0;        // slot 0 takes the first tie
            owner <= 1'b0;
            grant <= '0;
            start <= 1'b0;
        end else begin
            grant <= '0;
            start <= can_grant;
            if (can_grant) begin
                grant[pick] <= 1'b1;
                owner       <= pick;
                if (tie) begin
                    prio <= !prio;
                end
            end
        end
    end

    // held stays stable from grant until the response
    assign sel_req = held[owner];

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_rsp[i].rchar = rsp.rchar;
            slot_rsp[i].done  = rsp.done && (owner == 1'(i));
        end
    end

endmodule

`default_nettype wire

/* hdl/spi_client_slot.sv */
`default_nettype none

module spi_client_slot import spi_char_pkg::*; (
    input  logic                  S_CHAR_GO,
    input  logic                  S_RESETN,
    input  logic                  req,       // one-cycle strobe
    input  spi_req_t              req_data,
    output logic                  busy,
    output logic                  pending,   // waiting for a grant
    output spi_req_t              held,
    input  logic                  grant,
    input  spi_rsp_t              rsp,
    output logic [CHAR_NBITS-1:0] rchar,
    output logic                  done
);

    logic accept;

    assign accept = req && !busy; // strobe while busy is dropped

    always_ff @(posedge S_CHAR_GO) begin
        if (accept) begin
            held <= req_data;
        end
    end

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            busy    <= 1'b0;
            pending <= 1'b0;
            done    <= 1'b0;
            rchar   <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy    <= 1'b1;
                pending <= 1'b1;
            end
            if (grant) begin
                pending <= 1'b0;
            end
            if (rsp.done) begin
                done <= 1'b1;
                if (!held.cfg.tx_only) begin
                    rchar <= rsp.rchar;  // tx_only keeps the last value
                end
            end
            if (done) begin
                busy <= 1'b0;            // free one cycle after done
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/spi_master_top.sv */
`default_nettype none

module spi_master_top import spi_char_pkg::*; (
    input  logic                  S_CHAR_GO,
    input  logic                  S_RESETN,
    input  logic [NUM_SLOTS-1:0]  req,
    input  spi_req_t              req_data [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0]  busy,
    output logic [CHAR_NBITS-1:0] rchar [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0]  done,
    output logic                  sck,
    output logic                  mosi,
    input  logic                  miso,
    output logic                  cs_n
);

    logic [NUM_SLOTS-1:0] pending;
    logic [NUM_SLOTS-1:0] grant;
    spi_req_t             held [NUM_SLOTS];
    spi_rsp_t             slot_rsp [NUM_SLOTS];
    logic                 start;
    logic                 idle;
    spi_req_t             sel_req;
    spi_rsp_t             rsp;
    logic                 gen_run;
    logic                 gen_cpol;
    logic [DIV_W-1:0]     gen_div;
    logic                 lead;
    logic                 trail;

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        spi_client_slot u_slot (
            .S_CHAR_GO (S_CHAR_GO),
            .S_RESETN  (S_RESETN),
            .req       (req[i]),
            .req_data  (req_data[i]),
            .busy      (busy[i]),
            .pending   (pending[i]),
            .held      (held[i]),
            .grant     (grant[i]),
            .rsp       (slot_rsp[i]),
            .rchar     (rchar[i]),
            .done      (done[i])
        );
    end

    spi_bus_arbiter u_arb (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .pending   (pending),
        .held      (held),
        .idle      (idle),
        .grant     (grant),
        .start     (start),
        .sel_req   (sel_req),
        .rsp       (rsp),
        .slot_rsp  (slot_rsp)
    );

    spi_char_trx u_trx (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .start     (start),
        .req       (sel_req),
        .idle      (idle),
        .rsp       (rsp),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .gen_run   (gen_run),
        .gen_cpol  (gen_cpol),
        .gen_div   (gen_div),
        .lead      (lead),
        .trail     (trail)
    );

    spi_sck_gen u_sck (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .run       (gen_run),
        .cpol      (gen_cpol),
        .divider   (gen_div),
        .sck       (sck),
        .lead      (lead),
        .trail     (trail)
    );

endmodule

`default_nettype wire

/* tests/spi_slave_model.sv */
`default_nettype none

module spi_slave_model import spi_char_pkg::*; (
    input  logic                  sck,
    input  logic                  cs_n,
    input  logic                  mosi,
    output logic                  miso,
    input  logic                  cpha,     // mode of the next character
    input  logic                  rev,      // 1: msb first
    input  logic [LEN_W-1:0]      char_len,
    input  logic [CHAR_NBITS-1:0] reply,
    output logic [CHAR_NBITS-1:0] got       // mosi bits of the last character
);

    logic                  active;
    logic                  second;  // next edge is the trail edge
    logic                  sck_q;
    logic                  cpha_q;
    logic                  rev_q;
    logic [LEN_W-1:0]      idx;
    logic [LEN_W-1:0]      last_q;
    logic [CHAR_NBITS-1:0] reply_q;

    // pins are looked at 1 unit after they move, so the master side has settled
    initial begin
        miso   = 1'b0;
        got    = '0;
        active = 1'b0;
        second = 1'b0;
        sck_q  = 1'b0;
        forever begin
            @(sck or cs_n);
            #1;
            if (cs_n) begin
                active = 1'b0;
            end else if (!active) begin
                active  = 1'b1;
                second  = 1'b0;
                got     = '0;
                cpha_q  = cpha;
                rev_q   = rev;
                reply_q = reply;
                idx     = rev ? ((char_len == '0) ? 4'd15 : char_len) : 4'd0;
                last_q  = rev ? 4'd0 : ((char_len == '0) ? 4'd15 : char_len);
                if (!cpha) begin
                    miso = reply[idx]; // first bit before the first edge
                end
            end else if (sck != sck_q) begin
                if (!second) begin
                    if (cpha_q) miso = reply_q[idx];
                    else        got[idx] = mosi;
                end else begin
                    if (cpha_q) got[idx] = mosi;
                    if (idx != last_q) idx = rev_q ? idx - 4'd1 : idx + 4'd1;
                    if (!cpha_q) miso = reply_q[idx];
                end
                second = !second;
            end
            sck_q = sck; // a move at cs_n fall is not an edge
        end
    end

endmodule

`default_nettype wire

/* tests/spi_master_assert.sv */
`default_nettype none

module spi_master_assert import spi_char_pkg::*; (
    input logic                 S_CHAR_GO,
    input logic                 S_RESETN,
    input logic [NUM_SLOTS-1:0] req,
    input logic [NUM_SLOTS-1:0] busy,
    input logic [NUM_SLOTS-1:0] done,
    input logic                 sck,
    input logic                 cs_n
);

    a_cs_idle: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        (busy == '0) |-> cs_n)
        else $error("cs_n low while no slot is in service");

    a_sck_quiet: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        (cs_n && $past(cs_n)) |-> $stable(sck))
        else $error("sck moved while cs_n was high");

    a_one_done: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        !(done[0] && done[1]))
        else $error("done high in both slots");

    a_req0_free: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        req[0] |-> !busy[0])
        else $error("request to slot 0 while it was busy");

    a_req1_free: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        req[1] |-> !busy[1])
        else $error("request to slot 1 while it was busy");

endmodule

bind spi_master_top spi_master_assert u_assert (
    .S_CHAR_GO (S_CHAR_GO),
    .S_RESETN  (S_RESETN),
    .req       (req),
    .busy      (busy),
    .done      (done),
    .sck       (sck),
    .cs_n      (cs_n)
);

`default_nettype wire

/* tests/tb_spi_master.sv */
`default_nettype none

module tb_spi_master import spi_char_pkg::*; ();

    localparam int SEED      = 37310;
    localparam int NUM_CHARS = 200;
    localparam int WATCHDOG  = NUM_CHARS * (2 * 16 * 4 + 40) * 40;

    logic                  S_CHAR_GO;
    logic                  S_RESETN;
    logic [NUM_SLOTS-1:0]  req;
    spi_req_t              req_data [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]  busy;
    logic [CHAR_NBITS-1:0] rchar [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]  done;
    logic                  sck;
    logic                  mosi;
    logic                  miso;
    logic                  cs_n;
    logic                  slv_cpha;
    logic                  slv_rev;
    logic [LEN_W-1:0]      slv_len;
    logic [CHAR_NBITS-1:0] slv_reply;
    logic [CHAR_NBITS-1:0] slv_got;
    logic [CHAR_NBITS-1:0] prev_rchar [NUM_SLOTS]; // model of each slot's rchar
    int                    tie_winner;
    int                    sent;

    spi_master_top u_dut (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .req       (req),
        .req_data  (req_data),
        .busy      (busy),
        .rchar     (rchar),
        .done      (done),
        .sck       (sck),
        .mosi      (mosi),
        .miso      (miso),
        .cs_n      (cs_n)
    );

    spi_slave_model u_slave (
        .sck      (sck),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .miso     (miso),
        .cpha     (slv_cpha),
        .rev      (slv_rev),
        .char_len (slv_len),
        .reply    (slv_reply),
        .got      (slv_got)
    );

    always #20 S_CHAR_GO = !S_CHAR_GO;

    initial begin
        #(WATCHDOG);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired before all characters were done");
    end

    task automatic check_value(string name, logic [15:0] actual, logic [15:0] expected);
        assert (actual === expected) else begin
            $display("FAIL time %0t %s got %h expected %h", $time, name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond) else begin
            $display("FAIL time %0t %s", $time, what);
            $display("*** FAILED ***");
            $fatal(1, "%s", what);
        end
    endtask

    // length code 0 is a full 16-bit character
    function automatic logic [15:0] mask_for(logic [LEN_W-1:0] len);
        if (len == '0) return 16'hFFFF;
        return (16'h1 << (int'(len) + 1)) - 16'h1;
    endfunction

    function automatic spi_req_t random_req();
        spi_req_t r;
        r.cfg.cpol     = 1'($urandom % 2);
        r.cfg.cpha     = 1'($urandom % 2);
        r.cfg.rev      = 1'($urandom % 2);
        r.cfg.tx_only  = (($urandom % 6) == 0);
        r.cfg.loop     = (($urandom % 5) == 0);
        r.cfg.char_len = LEN_W'($urandom % 16);
        r.cfg.divider  = DIV_W'($urandom % 4);
        r.wchar        = 16'($urandom);
        return r;
    endfunction

    task automatic load_slave(spi_req_t r, logic [15:0] reply);
        slv_cpha  = r.cfg.cpha;
        slv_rev   = r.cfg.rev;
        slv_len   = r.cfg.char_len;
        slv_reply = reply;
    endtask

    task automatic wait_done(int s);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge S_CHAR_GO);
            check_true(!done[1 - s], $sformatf("slot %0d finished out of turn", 1 - s));
            seen = done[s];
        end
    endtask

    task automatic run_batch();
        spi_req_t    r [NUM_SLOTS];
        logic [15:0] rep [NUM_SLOTS];
        logic [15:0] exp_r;
        int          order[$];
        int          s;
        logic        tie;
        tie = (($urandom % 4) == 0) && (sent < NUM_CHARS - 1); // sometimes both at once
        for (int i = 0; i < NUM_SLOTS; i++) begin
            r[i]   = random_req();
            rep[i] = 16'($urandom);
        end
        if (tie) begin
            order.push_back(tie_winner);
            order.push_back(1 - tie_winner);
            tie_winner = 1 - tie_winner;
        end else begin
            order.push_back(int'($urandom % 2));
        end
        load_slave(r[order[0]], rep[order[0]]);
        foreach (order[k]) begin
            req[order[k]]      = 1'b1;
            req_data[order[k]] = r[order[k]];
        end
        @(negedge S_CHAR_GO);
        req = '0;
        foreach (order[k]) begin
            s = order[k];
            if (k > 0) load_slave(r[s], rep[s]);
            wait_done(s);
            if (r[s].cfg.tx_only) exp_r = prev_rchar[s];
            else if (r[s].cfg.loop) exp_r = r[s].wchar & mask_for(r[s].cfg.char_len);
            else exp_r = rep[s] & mask_for(r[s].cfg.char_len);
            prev_rchar[s] = exp_r;
            check_value("slave mosi char", slv_got, r[s].wchar & mask_for(r[s].cfg.char_len));
            check_value($sformatf("rchar[%0d]", s), rchar[s], exp_r);
            check_value("sck", 16'(sck), 16'(r[s].cfg.cpol)); // rests at this cpol
            sent++;
        end
        while (busy != '0) begin
            @(negedge S_CHAR_GO);
            check_value("done", 16'(done), 16'h0); // one pulse per character
        end
    endtask

    initial begin
        void'($urandom(SEED));
        S_CHAR_GO  = 1'b0;
        S_RESETN   = 1'b0;
        req        = '0;
        req_data[0] = '0;
        req_data[1] = '0;
        slv_cpha   = 1'b0;
        slv_rev    = 1'b0;
        slv_len    = '0;
        slv_reply  = '0;
        prev_rchar[0] = '0;
        prev_rchar[1] = '0;
        tie_winner = 0;             // slot 0 takes the first tie
        sent       = 0;
        repeat (16) @(posedge S_CHAR_GO);
        @(negedge S_CHAR_GO);
        S_RESETN = 1'b1;
        repeat (4) begin
            @(negedge S_CHAR_GO);
            check_value("cs_n", 16'(cs_n), 16'h1);
            check_value("busy", 16'(busy), 16'h0);
            check_value("done", 16'(done), 16'h0);
            check_value("mosi", 16'(mosi), 16'h1);
            check_value("sck", 16'(sck), 16'h0);
        end
        while (sent < NUM_CHARS) run_batch();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/spi_char_pkg.sv
hdl/spi_sck_gen.sv
hdl/spi_char_trx.sv
hdl/spi_bus_arbiter.sv
hdl/spi_client_slot.sv
hdl/spi_master_top.sv
tests/spi_slave_model.sv
tests/spi_master_assert.sv
tests/tb_spi_master.sv

/* run.sh */
#!/bin/sh
# builds the SPI master testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_spi_master \
    -f list.f \
    -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

if [ ! -x ./obj_dir/sim_tb ]; then
    echo "simulation executable not found"
    exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0
